/* all.f */
+incdir+.
issue_pkg.sv
instr_fields.sv
operand_resolve.sv
issue_ctrl.sv
issue_packer.sv
decode_issue.sv
decode_issue_chk.sv
tb_decode_issue.sv

/* decode_issue.sv */
`timescale 1ns/1ns
`default_nettype none
`include "issue_defines.svh"

module decode_issue (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       flush_i,
    input  issue_pkg::iq_entry_t       iq_entry_i,
    input  logic                       iq_empty_i,
    output logic                       iq_read_o,
    output logic [`REG_ADDR_W-1:0]     rs1_o,
    output logic [`REG_ADDR_W-1:0]     rs2_o,
    input  issue_pkg::rf_read_t        rf_entry_i,
    output issue_pkg::rename_t         rename_o,
    input  issue_pkg::rob_bypass_arr_t rob_bypass_i,
    input  logic [`TAG_W-1:0]          rob_free_tag_i,
    input  logic                       rob_full_i,
    output issue_pkg::rob_alloc_t      rob_alloc_o,
    input  logic                       alu_rs_full_i,
    output issue_pkg::alu_issue_t      alu_issue_o,
    input  logic                       cmp_rs_full_i,
    output issue_pkg::cmp_issue_t      cmp_issue_o
);

    issue_pkg::decoded_t      dec;
    issue_pkg::operand_t      rs1_op;
    issue_pkg::operand_t      rs2_op;
    logic                     fire;
    issue_pkg::issue_target_e fire_target;
    logic                     fwd_valid;
    logic [`REG_ADDR_W-1:0]   fwd_rd;
    logic [`TAG_W-1:0]        fwd_tag;

    instr_fields u_fields (
        .iq_entry_i (iq_entry_i),
        .decoded_o  (dec)
    );

    // register file read addresses
    assign rs1_o = dec.rs1;
    assign rs2_o = dec.rs2;

    issue_ctrl u_ctrl (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .dec_i          (dec),
        .iq_empty_i     (iq_empty_i),
        .rob_full_i     (rob_full_i),
        .rob_free_tag_i (rob_free_tag_i),
        .alu_rs_full_i  (alu_rs_full_i),
        .cmp_rs_full_i  (cmp_rs_full_i),
        .iq_read_o      (iq_read_o),
        .rename_o       (rename_o),
        .fire_o         (fire),
        .fire_target_o  (fire_target),
        .fwd_valid_o    (fwd_valid),
        .fwd_rd_o       (fwd_rd),
        .fwd_tag_o      (fwd_tag)
    );

    operand_resolve u_rs1 (
        .src_i        (dec.rs1),
        .rf_value_i   (rf_entry_i.rs1_value),
        .rf_tag_i     (rf_entry_i.rs1_tag),
        .rob_bypass_i (rob_bypass_i),
        .fwd_valid_i  (fwd_valid),
        .fwd_rd_i     (fwd_rd),
        .fwd_tag_i    (fwd_tag),
        .operand_o    (rs1_op)
    );

    operand_resolve u_rs2 (
        .src_i        (dec.rs2),
        .rf_value_i   (rf_entry_i.rs2_value),
        .rf_tag_i     (rf_entry_i.rs2_tag),
        .rob_bypass_i (rob_bypass_i),
        .fwd_valid_i  (fwd_valid),
        .fwd_rd_i     (fwd_rd),
        .fwd_tag_i    (fwd_tag),
        .operand_o    (rs2_op)
    );

    issue_packer u_packer (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .fire_i        (fire),
        .fire_target_i (fire_target),
        .dec_i         (dec),
        .rs1_op_i      (rs1_op),
        .rs2_op_i      (rs2_op),
        .rob_tag_i     (rob_free_tag_i),
        .alu_issue_o   (alu_issue_o),
        .cmp_issue_o   (cmp_issue_o),
        .rob_alloc_o   (rob_alloc_o)
    );

endmodule

`default_nettype wire

/* decode_issue_chk.sv */
`timescale 1ns/1ns
`default_nettype none
`include "issue_defines.svh"

module decode_issue_chk (
    input wire logic                  clk,
    input wire logic                  rst_n_i,
    input wire logic                  iq_empty_i,
    input wire logic                  iq_read_i,
    input wire logic                  fire_i,
    input wire issue_pkg::alu_issue_t alu_issue_i,
    input wire issue_pkg::cmp_issue_t cmp_issue_i,
    input wire issue_pkg::rob_alloc_t rob_alloc_i
);

    // outputs quiet while reset is held
    reset_quiet: assert property (@(posedge clk)
        !rst_n_i |-> !iq_read_i && !alu_issue_i.valid && !cmp_issue_i.valid
                     && !rob_alloc_i.valid)
        else $error("output active during reset");

    // one station gets the packet
    one_station: assert property (@(posedge clk) disable iff (!rst_n_i)
        fire_i |=> (alu_issue_i.valid ^ cmp_issue_i.valid))
        else $error("issued instruction did not reach exactly one station");

    rob_matches: assert property (@(posedge clk) disable iff (!rst_n_i)
        rob_alloc_i.valid == (alu_issue_i.valid || cmp_issue_i.valid))
        else $error("rob allocation valid differs from station valids");

    no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n_i)
        iq_empty_i |-> !iq_read_i)
        else $error("queue popped while empty");

endmodule

`default_nettype wire

/* instr_fields.sv */
`timescale 1ns/1ns
`default_nettype none
`include "issue_defines.svh"

module instr_fields (
    input  issue_pkg::iq_entry_t iq_entry_i,
    output issue_pkg::decoded_t  decoded_o
);

    logic [`XLEN-1:0]       instr;
    issue_pkg::rv_opcode_e  opcode;
    logic [2:0]             funct3;
    logic                   funct7_b5;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       i_imm;
    logic [`XLEN-1:0]       b_imm;
    logic [`XLEN-1:0]       u_imm;
    logic                   is_cmp_funct;

    assign instr     = iq_entry_i.instr;
    assign opcode    = issue_pkg::rv_opcode_e'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];
    assign rd        = instr[11:7];

    assign i_imm = {{(`XLEN-12){instr[31]}}, instr[31:20]};
    assign b_imm = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'h000};

    // slt/sltu and their immediate forms go to the compare station
    assign is_cmp_funct = (funct3 == 3'b010) || (funct3 == 3'b011);

    always_comb begin
        decoded_o        = '0;
        decoded_o.opcode = opcode;
        decoded_o.rs1    = instr[19:15];
        decoded_o.rs2    = instr[24:20];
        decoded_o.rd     = rd;
        decoded_o.pc     = iq_entry_i.pc;
        decoded_o.cmp_op = issue_pkg::cmp_op_e'(funct3);
        decoded_o.alu_op = issue_pkg::alu_add;
        decoded_o.target = issue_pkg::tgt_drop;

        case (opcode)
            issue_pkg::op_lui, issue_pkg::op_auipc: begin
                decoded_o.imm = u_imm;
                if (rd != '0) begin
                    decoded_o.target = issue_pkg::tgt_alu;
                end
            end
            issue_pkg::op_imm, issue_pkg::op_reg: begin
                decoded_o.imm      = i_imm;
                decoded_o.uses_rs2 = (opcode == issue_pkg::op_reg);
                case (funct3)
                    3'b000: begin
                        // subtract only exists in register form
                        if ((opcode == issue_pkg::op_reg) && funct7_b5) begin
                            decoded_o.alu_op = issue_pkg::alu_sub;
                        end
                    end
                    3'b001: decoded_o.alu_op = issue_pkg::alu_sll;
                    3'b100: decoded_o.alu_op = issue_pkg::alu_xor;
                    3'b101: begin
                        decoded_o.alu_op = funct7_b5 ? issue_pkg::alu_sra : issue_pkg::alu_srl;
                    end
                    3'b110: decoded_o.alu_op = issue_pkg::alu_or;
                    3'b111: decoded_o.alu_op = issue_pkg::alu_and;
                    default: ;
                endcase
                if (rd != '0) begin
                    decoded_o.target = is_cmp_funct ? issue_pkg::tgt_cmp : issue_pkg::tgt_alu;
                end
            end
            issue_pkg::op_br: begin
                // rd bits hold immediate here, no register write
                decoded_o.rd       = '0;
                decoded_o.uses_rs2 = 1'b1;
                decoded_o.branch   = 1'b1;
                decoded_o.b_imm    = b_imm;
                decoded_o.target   = issue_pkg::tgt_cmp;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* issue_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none
`include "issue_defines.svh"

module issue_ctrl (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     flush_i,
    input  issue_pkg::decoded_t      dec_i,
    input  logic                     iq_empty_i,
    input  logic                     rob_full_i,
    input  logic [`TAG_W-1:0]        rob_free_tag_i,
    input  logic                     alu_rs_full_i,
    input  logic                     cmp_rs_full_i,
    output logic                     iq_read_o,
    output issue_pkg::rename_t       rename_o,
    output logic                     fire_o,
    output issue_pkg::issue_target_e fire_target_o,
    output logic                     fwd_valid_o,
    output logic [`REG_ADDR_W-1:0]   fwd_rd_o,
    output logic [`TAG_W-1:0]        fwd_tag_o
);

    logic active_q;
    logic head_ok;
    logic rob_ok;
    logic target_ok;
    logic accept;
    logic issue_accept;

    // stage idles for one cycle after reset release
    assign head_ok = active_q && !iq_empty_i && !flush_i;
    assign rob_ok  = !rob_full_i && (rob_free_tag_i != '0);

    // each target only waits on its own resources
    always_comb begin
        case (dec_i.target)
            issue_pkg::tgt_alu:  target_ok = rob_ok && !alu_rs_full_i;
            issue_pkg::tgt_cmp:  target_ok = rob_ok && !cmp_rs_full_i;
            issue_pkg::tgt_drop: target_ok = 1'b1;
            default:             target_ok = 1'b0;
        endcase
    end

    assign accept       = head_ok && target_ok;
    assign issue_accept = accept && (dec_i.target != issue_pkg::tgt_drop);

    assign iq_read_o = accept;
    assign fire_o    = issue_accept;

    always_comb begin
        if (issue_accept) begin
            fire_target_o = dec_i.target;
        end else begin
            fire_target_o = issue_pkg::tgt_none;
        end
    end

    // branches carry rd of zero so they never rename
    always_comb begin
        rename_o.we  = issue_accept && (dec_i.rd != '0);
        rename_o.rd  = dec_i.rd;
        rename_o.tag = rob_free_tag_i;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            active_q    <= 1'b0;
            fwd_valid_o <= 1'b0;
            fwd_rd_o    <= '0;
            fwd_tag_o   <= '0;
        end else begin
            active_q <= 1'b1;
            if (rename_o.we) begin
                fwd_valid_o <= 1'b1;
                fwd_rd_o    <= dec_i.rd;
                fwd_tag_o   <= rob_free_tag_i;
            end else begin
                // stall, drop or flush breaks the back-to-back chain
                fwd_valid_o <= 1'b0;
                fwd_rd_o    <= '0;
                fwd_tag_o   <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* issue_defines.svh */
`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// datapath width
`define XLEN 32

// architectural register index
`define REG_ADDR_W 5

// reorder buffer tags, tag 0 means none
`define TAG_W 4
`define ROB_DEPTH 16

`endif

/* issue_packer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "issue_defines.svh"

module issue_packer (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     flush_i,
    input  logic                     fire_i,
    input  issue_pkg::issue_target_e fire_target_i,
    input  issue_pkg::decoded_t      dec_i,
    input  issue_pkg::operand_t      rs1_op_i,
    input  issue_pkg::operand_t      rs2_op_i,
    input  logic [`TAG_W-1:0]        rob_tag_i,
    output issue_pkg::alu_issue_t    alu_issue_o,
    output issue_pkg::cmp_issue_t    cmp_issue_o,
    output issue_pkg::rob_alloc_t    rob_alloc_o
);

    logic                fire_alu;
    logic                fire_cmp;
    issue_pkg::operand_t alu_rs1;
    issue_pkg::operand_t rs2_sel;

    assign fire_alu = fire_i && !flush_i && (fire_target_i == issue_pkg::tgt_alu);
    assign fire_cmp = fire_i && !flush_i && (fire_target_i == issue_pkg::tgt_cmp);

    // lui adds to zero, auipc adds to pc
    always_comb begin
        alu_rs1 = rs1_op_i;
        if (dec_i.opcode == issue_pkg::op_lui) begin
            alu_rs1 = '{value: '0, tag: '0, valid: 1'b1};
        end else if (dec_i.opcode == issue_pkg::op_auipc) begin
            alu_rs1 = '{value: dec_i.pc, tag: '0, valid: 1'b1};
        end
    end

    // immediate forms of both stations take imm in the second slot
    always_comb begin
        if (dec_i.uses_rs2) begin
            rs2_sel = rs2_op_i;
        end else begin
            rs2_sel = '{value: dec_i.imm, tag: '0, valid: 1'b1};
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            alu_issue_o <= '0;
            cmp_issue_o <= '0;
            rob_alloc_o <= '0;
        end else begin
            alu_issue_o.valid <= fire_alu;
            cmp_issue_o.valid <= fire_cmp;
            rob_alloc_o.valid <= fire_alu || fire_cmp;

            if (fire_alu) begin
                alu_issue_o.op      <= dec_i.alu_op;
                alu_issue_o.rs1     <= alu_rs1;
                alu_issue_o.rs2     <= rs2_sel;
                alu_issue_o.rob_tag <= rob_tag_i;
            end

            if (fire_cmp) begin
                cmp_issue_o.op      <= dec_i.cmp_op;
                cmp_issue_o.branch  <= dec_i.branch;
                cmp_issue_o.rs1     <= rs1_op_i;
                cmp_issue_o.rs2     <= rs2_sel;
                cmp_issue_o.pc      <= dec_i.pc;
                cmp_issue_o.b_imm   <= dec_i.b_imm;
                cmp_issue_o.rob_tag <= rob_tag_i;
            end

            if (fire_alu || fire_cmp) begin
                rob_alloc_o.pc     <= dec_i.pc;
                rob_alloc_o.opcode <= dec_i.opcode;
                rob_alloc_o.rd     <= dec_i.rd;
            end
        end
    end

endmodule

`default_nettype wire

/* issue_pkg.sv */
`default_nettype none
`include "issue_defines.svh"

package issue_pkg;

    typedef enum logic [6:0] {
        op_lui      = 7'b0110111,
        op_auipc    = 7'b0010111,
        op_jal      = 7'b1101111,
        op_jalr     = 7'b1100111,
        op_br       = 7'b1100011,
        op_load     = 7'b0000011,
        op_store    = 7'b0100011,
        op_imm      = 7'b0010011,
        op_reg      = 7'b0110011,
        op_misc_mem = 7'b0001111,
        op_system   = 7'b1110011
    } rv_opcode_e;

    // funct3 slots of slt/sltu reused for sub and sra
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sub = 3'b010,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_sra = 3'b011,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_e;

    // encoded as funct3
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } cmp_op_e;

    typedef enum logic [1:0] {
        tgt_alu,
        tgt_cmp,
        tgt_drop,
        tgt_none
    } issue_target_e;

    typedef struct packed {
        logic [`XLEN-1:0] instr;
        logic [`XLEN-1:0] pc;
    } iq_entry_t;

    typedef struct packed {
        logic [`XLEN-1:0]  rs1_value;
        logic [`TAG_W-1:0] rs1_tag;
        logic [`XLEN-1:0]  rs2_value;
        logic [`TAG_W-1:0] rs2_tag;
    } rf_read_t;

    typedef struct packed {
        logic             ready;
        logic [`XLEN-1:0] value;
    } rob_bypass_t;

    typedef rob_bypass_t [`ROB_DEPTH-1:0] rob_bypass_arr_t;

    // valid means the value is present
    typedef struct packed {
        logic [`XLEN-1:0]  value;
        logic [`TAG_W-1:0] tag;
        logic              valid;
    } operand_t;

    typedef struct packed {
        rv_opcode_e             opcode;
        issue_target_e          target;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   uses_rs2;
        alu_op_e                alu_op;
        cmp_op_e                cmp_op;
        logic                   branch;
        logic [`XLEN-1:0]       imm;
        logic [`XLEN-1:0]       b_imm;
        logic [`XLEN-1:0]       pc;
    } decoded_t;

    typedef struct packed {
        logic                   we;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`TAG_W-1:0]      tag;
    } rename_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        rv_opcode_e             opcode;
        logic [`REG_ADDR_W-1:0] rd;
    } rob_alloc_t;

    typedef struct packed {
        logic              valid;
        alu_op_e           op;
        operand_t          rs1;
        operand_t          rs2;
        logic [`TAG_W-1:0] rob_tag;
    } alu_issue_t;

    typedef struct packed {
        logic              valid;
        cmp_op_e           op;
        logic              branch;
        operand_t          rs1;
        operand_t          rs2;
        logic [`XLEN-1:0]  pc;
        logic [`XLEN-1:0]  b_imm;
        logic [`TAG_W-1:0] rob_tag;
    } cmp_issue_t;

endpackage

`default_nettype wire

/* operand_resolve.sv */
`timescale 1ns/1ns
`default_nettype none
`include "issue_defines.svh"

module operand_resolve (
    input  logic [`REG_ADDR_W-1:0]     src_i,
    input  logic [`XLEN-1:0]           rf_value_i,
    input  logic [`TAG_W-1:0]          rf_tag_i,
    input  issue_pkg::rob_bypass_arr_t rob_bypass_i,
    input  logic                       fwd_valid_i,
    input  logic [`REG_ADDR_W-1:0]     fwd_rd_i,
    input  logic [`TAG_W-1:0]          fwd_tag_i,
    output issue_pkg::operand_t        operand_o
);

    logic                   fwd_hit;
    logic                   bypass_hit;
    issue_pkg::rob_bypass_t rob_entry;

    // producer issued last cycle, register file not yet renamed for us
    assign fwd_hit = fwd_valid_i && (src_i != '0) && (src_i == fwd_rd_i);

    assign rob_entry  = rob_bypass_i[rf_tag_i];
    assign bypass_hit = (rf_tag_i != '0) && rob_entry.ready;

    always_comb begin
        if (fwd_hit) begin
            operand_o.value = '0;
            operand_o.tag   = fwd_tag_i;
            operand_o.valid = 1'b0;
        end else if (bypass_hit) begin
            operand_o.value = rob_entry.value;
            operand_o.tag   = '0;
            operand_o.valid = 1'b1;
        end else begin
            operand_o.value = rf_value_i;
            operand_o.tag   = rf_tag_i;
            operand_o.valid = (rf_tag_i == '0);
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build and run the decode/issue testbench, exit status reports pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --assert -f all.f --top-module tb_decode_issue -o sim_decode_issue \
    && ./obj_dir/sim_decode_issue \
    || exit 1

/* tb_decode_issue.sv */
`timescale 1ns/1ns
`default_nettype none
`include "issue_defines.svh"

module tb_decode_issue;

    logic clk;
    logic rst_n_i;
    logic flush_i;
    issue_pkg::iq_entry_t       iq_entry_i;
    logic                       iq_empty_i;
    logic                       iq_read_o;
    logic [`REG_ADDR_W-1:0]     rs1_o;
    logic [`REG_ADDR_W-1:0]     rs2_o;
    issue_pkg::rf_read_t        rf_entry_i;
    issue_pkg::rename_t         rename_o;
    issue_pkg::rob_bypass_arr_t rob_bypass_i;
    logic [`TAG_W-1:0]          rob_free_tag_i;
    logic                       rob_full_i;
    issue_pkg::rob_alloc_t      rob_alloc_o;
    logic                       alu_rs_full_i;
    issue_pkg::alu_issue_t      alu_issue_o;
    logic                       cmp_rs_full_i;
    issue_pkg::cmp_issue_t      cmp_issue_o;

    // stimulus knobs set by the test sequence
    logic s_empty, s_flush, s_alu_full, s_cmp_full, s_rob_full, s_zero_tag;
    logic [`TAG_W-1:0] s_tag1, s_tag2;
    issue_pkg::rob_bypass_arr_t byp;

    // reference model state
    logic                   m_fwd_v;
    logic [`REG_ADDR_W-1:0] m_fwd_rd;
    logic [`TAG_W-1:0]      m_fwd_tag;
    issue_pkg::alu_issue_t  exp_alu;
    issue_pkg::cmp_issue_t  exp_cmp;
    issue_pkg::rob_alloc_t  exp_rob;
    logic [31:0]            lfsr_q;

    decode_issue dut0 (.*);

    bind decode_issue decode_issue_chk u_chk (
        .clk(clk), .rst_n_i(rst_n_i), .iq_empty_i(iq_empty_i), .iq_read_i(iq_read_o),
        .fire_i(fire), .alu_issue_i(alu_issue_o), .cmp_issue_i(cmp_issue_o),
        .rob_alloc_i(rob_alloc_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (2000) @(posedge clk);
        $display("TB FAILED");
        $fatal(1, "timeout, test sequence did not finish within 2000 cycles");
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] enc_i(input [2:0] f3, input [4:0] rd, input [4:0] rs1,
                                          input [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_r(input f7b5, input [2:0] f3, input [4:0] rd,
                                          input [4:0] rs1, input [4:0] rs2);
        return {1'b0, f7b5, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_u(input [6:0] opc, input [4:0] rd, input [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input [2:0] f3, input [4:0] rs1, input [4:0] rs2,
                                          input [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    // forward beats bypass beats register file
    function automatic issue_pkg::operand_t expect_operand(input [4:0] src, input [31:0] val,
                                                           input [3:0] tag);
        issue_pkg::operand_t o;
        if (m_fwd_v && src != 0 && src == m_fwd_rd) begin
            o = '{value: '0, tag: m_fwd_tag, valid: 1'b0};
        end else if (tag != 0 && byp[tag].ready) begin
            o = '{value: byp[tag].value, tag: '0, valid: 1'b1};
        end else begin
            o = '{value: val, tag: tag, valid: (tag == 0)};
        end
        return o;
    endfunction

    task automatic check_val(input string name, input logic [159:0] got,
                             input logic [159:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            $display("TB FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    // kind 0 alu, 1 compare, 2 drop; rs1_mode 0 register, 1 zero, 2 pc
    task automatic step(input logic [31:0] instr, input int kind, input logic [2:0] op,
                        input logic use_rs2, input logic [31:0] imm, input int rs1_mode,
                        input logic exp_acc);
        logic [31:0] pc, v1, v2;
        logic [3:0] ftag;
        logic [4:0] rd;
        logic br, we;
        issue_pkg::operand_t o1, o2;
        pc = rand_bits(30) << 2;
        v1 = rand_bits(32);
        v2 = rand_bits(32);
        ftag = 4'(rand_bits(4));
        if (ftag == 0) ftag = 4'd1;
        if (s_zero_tag) ftag = 4'd0;
        br = (instr[6:0] == 7'b1100011);
        rd = br ? 5'd0 : instr[11:7];
        @(posedge clk);
        iq_entry_i     <= '{instr: instr, pc: pc};
        iq_empty_i     <= s_empty;
        flush_i        <= s_flush;
        rf_entry_i     <= '{rs1_value: v1, rs1_tag: s_tag1, rs2_value: v2, rs2_tag: s_tag2};
        rob_bypass_i   <= byp;
        rob_free_tag_i <= ftag;
        rob_full_i     <= s_rob_full;
        alu_rs_full_i  <= s_alu_full;
        cmp_rs_full_i  <= s_cmp_full;
        @(negedge clk);
        // packets of the previous accept
        if (exp_alu.valid) check_val("alu_issue_o", 160'(alu_issue_o), 160'(exp_alu));
        else check_val("alu_issue_o.valid", 160'(alu_issue_o.valid), 160'(0));
        if (exp_cmp.valid) check_val("cmp_issue_o", 160'(cmp_issue_o), 160'(exp_cmp));
        else check_val("cmp_issue_o.valid", 160'(cmp_issue_o.valid), 160'(0));
        if (exp_rob.valid) check_val("rob_alloc_o", 160'(rob_alloc_o), 160'(exp_rob));
        else check_val("rob_alloc_o.valid", 160'(rob_alloc_o.valid), 160'(0));
        check_val("iq_read_o", 160'(iq_read_o), 160'(exp_acc));
        check_val("rs1_o", 160'(rs1_o), 160'(instr[19:15]));
        check_val("rs2_o", 160'(rs2_o), 160'(instr[24:20]));
        we = exp_acc && kind != 2 && rd != 0;
        check_val("rename_o.we", 160'(rename_o.we), 160'(we));
        if (we) begin
            check_val("rename_o.rd", 160'(rename_o.rd), 160'(rd));
            check_val("rename_o.tag", 160'(rename_o.tag), 160'(ftag));
        end
        o1 = expect_operand(instr[19:15], v1, s_tag1);
        if (use_rs2) begin
            o2 = expect_operand(instr[24:20], v2, s_tag2);
        end else begin
            o2 = '{value: imm, tag: '0, valid: 1'b1};
        end
        exp_alu = '0;
        exp_cmp = '0;
        exp_rob = '0;
        if (exp_acc && kind == 0) begin
            if (rs1_mode == 1) o1 = '{value: '0, tag: '0, valid: 1'b1};
            if (rs1_mode == 2) o1 = '{value: pc, tag: '0, valid: 1'b1};
            exp_alu = '{valid: 1'b1, op: issue_pkg::alu_op_e'(op), rs1: o1, rs2: o2,
                        rob_tag: ftag};
        end
        if (exp_acc && kind == 1) begin
            exp_cmp = '{valid: 1'b1, op: issue_pkg::cmp_op_e'(op), branch: br, rs1: o1,
                        rs2: o2, pc: pc, b_imm: (br ? imm : 32'd0), rob_tag: ftag};
        end
        if (exp_acc && kind != 2) begin
            exp_rob = '{valid: 1'b1, pc: pc, opcode: issue_pkg::rv_opcode_e'(instr[6:0]),
                        rd: rd};
        end
        m_fwd_v   = we;
        m_fwd_rd  = we ? rd : 5'd0;
        m_fwd_tag = we ? ftag : 4'd0;
    endtask

    initial begin
        lfsr_q = 32'd93473;
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        iq_entry_i = '0;
        // queue head present while reset is held
        iq_empty_i = 1'b0;
        rf_entry_i = '0;
        rob_bypass_i = '0;
        rob_free_tag_i = '0;
        rob_full_i = 1'b0;
        alu_rs_full_i = 1'b0;
        cmp_rs_full_i = 1'b0;
        {s_empty, s_flush, s_alu_full, s_cmp_full, s_rob_full, s_zero_tag} = '0;
        s_tag1 = '0;
        s_tag2 = '0;
        {m_fwd_v, m_fwd_rd, m_fwd_tag} = '0;
        exp_alu = '0;
        exp_cmp = '0;
        exp_rob = '0;
        for (int i = 0; i < `ROB_DEPTH; i++) byp[i] = '{ready: 1'b0, value: rand_bits(32)};
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        s_empty = 1'b1;
        step(32'd0, 2, 3'd0, 0, 32'd0, 0, 0);
        s_empty = 1'b0;

        // alu class with idle tags
        step(enc_i(3'b000, 5'd1, 5'd2, 12'd5), 0, issue_pkg::alu_add, 0, 32'd5, 0, 1);
        step(enc_r(1'b0, 3'b000, 5'd3, 5'd4, 5'd5), 0, issue_pkg::alu_add, 1, 0, 0, 1);
        step(enc_r(1'b1, 3'b000, 5'd3, 5'd4, 5'd5), 0, issue_pkg::alu_sub, 1, 0, 0, 1);
        step(enc_i(3'b100, 5'd2, 5'd9, 12'hff0), 0, issue_pkg::alu_xor, 0, 32'hffff_fff0,
             0, 1);
        step(enc_u(7'b0110111, 5'd6, 20'habcde), 0, issue_pkg::alu_add, 0, 32'habcde000, 1, 1);
        step(enc_u(7'b0010111, 5'd7, 20'h00012), 0, issue_pkg::alu_add, 0, 32'h00012000, 2, 1);

        // compare class and branches
        step(enc_i(3'b010, 5'd8, 5'd9, 12'hffd), 1, issue_pkg::slt, 0, 32'hffff_fffd, 0, 1);
        step(enc_r(1'b0, 3'b011, 5'd10, 5'd11, 5'd12), 1, issue_pkg::sltu, 1, 0, 0, 1);
        step(enc_b(3'b001, 5'd13, 5'd14, 13'h1ff8), 1, issue_pkg::bne, 1, 32'hffff_fff8, 0, 1);
        step(enc_b(3'b110, 5'd15, 5'd16, 13'h0040), 1, issue_pkg::bltu, 1, 32'h40, 0, 1);

        // bypass from a ready entry, then a pending tag
        byp[5].ready = 1'b1;
        s_tag1 = 4'd5;
        s_tag2 = 4'd7;
        step(enc_r(1'b0, 3'b110, 5'd17, 5'd18, 5'd19), 0, issue_pkg::alu_or, 1, 0, 0, 1);
        s_tag1 = 4'd0;
        s_tag2 = 4'd0;

        // back-to-back dependency
        step(enc_i(3'b000, 5'd20, 5'd0, 12'd1), 0, issue_pkg::alu_add, 0, 32'd1, 0, 1);
        step(enc_r(1'b0, 3'b111, 5'd21, 5'd20, 5'd20), 0, issue_pkg::alu_and, 1, 0, 0, 1);
        step(enc_r(1'b0, 3'b010, 5'd22, 5'd21, 5'd3), 1, issue_pkg::slt, 1, 0, 0, 1);

        // back-pressure per target
        s_alu_full = 1'b1;
        step(enc_i(3'b111, 5'd1, 5'd2, 12'd3), 0, issue_pkg::alu_and, 0, 32'd3, 0, 0);
        step(enc_i(3'b011, 5'd1, 5'd2, 12'd3), 1, issue_pkg::sltu, 0, 32'd3, 0, 1);
        s_alu_full = 1'b0;
        s_cmp_full = 1'b1;
        step(enc_b(3'b000, 5'd1, 5'd2, 13'h10), 1, issue_pkg::beq, 1, 32'h10, 0, 0);
        s_cmp_full = 1'b0;
        s_rob_full = 1'b1;
        step(enc_i(3'b001, 5'd4, 5'd2, 12'd3), 0, issue_pkg::alu_sll, 0, 32'd3, 0, 0);
        s_rob_full = 1'b0;
        s_zero_tag = 1'b1;
        step(enc_i(3'b001, 5'd4, 5'd2, 12'd3), 0, issue_pkg::alu_sll, 0, 32'd3, 0, 0);
        s_zero_tag = 1'b0;
        s_empty = 1'b1;
        step(enc_i(3'b001, 5'd4, 5'd2, 12'd3), 0, issue_pkg::alu_sll, 0, 32'd3, 0, 0);
        s_empty = 1'b0;
        // x0 destination is consumed without issue
        step(enc_i(3'b000, 5'd0, 5'd1, 12'd1), 2, issue_pkg::alu_add, 0, 32'd1, 0, 1);

        // flush clears forwarding
        step(enc_i(3'b000, 5'd23, 5'd1, 12'd2), 0, issue_pkg::alu_add, 0, 32'd2, 0, 1);
        s_flush = 1'b1;
        step(enc_r(1'b0, 3'b000, 5'd24, 5'd23, 5'd0), 0, issue_pkg::alu_add, 1, 0, 0, 0);
        s_flush = 1'b0;
        s_tag1 = 4'd9;
        step(enc_r(1'b0, 3'b000, 5'd24, 5'd23, 5'd0), 0, issue_pkg::alu_add, 1, 0, 0, 1);
        s_tag1 = 4'd0;
        s_empty = 1'b1;
        step(32'd0, 2, 3'd0, 0, 32'd0, 0, 0);

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
